//--- source/md_pkg.sv
// ==========================================================
// multiply/divide unit, external view
// operand widths, opcodes and the request struct
// ==========================================================

package md_pkg;

  // operand and result width
  localparam int DATA_W = 32;

  // partial-product slice width
  localparam int HALF_W = 16;

  // 32-bit partial sum plus sign and carry
  localparam int ACC_W = 34;

  // divide step counter
  localparam int CNT_W = 5;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // signed_mode[0] marks operand A as signed, signed_mode[1] operand B
  typedef struct packed {
    md_op_e            op;
    logic [1:0]        signed_mode;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
  } md_req_t;

endpackage

//--- source/md_state_pkg.sv
// ==========================================================
// multiply/divide unit, internal FSM state encodings
// ==========================================================

package md_state_pkg;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_BUSY,
    CTRL_ACK
  } ctrl_state_e;

  // one state per 16x16 partial product
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

//--- source/md_req_ctrl.sv
// ==========================================================
// multiply/divide request controller
// four-phase req/ack front end, starts the selected unit
// and holds its result until the requester lets go
// ==========================================================

`timescale 1ns/1ps

module md_req_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  md_pkg::md_req_t             req_data_i,
  output logic                        ack_o,
  output logic [md_pkg::DATA_W-1:0]   result_o,
  output md_pkg::md_req_t             op_o,
  output logic                        mult_start_o,
  output logic                        div_start_o,
  input  logic                        mult_done_i,
  input  logic [md_pkg::DATA_W-1:0]   mult_result_i,
  input  logic                        div_done_i,
  input  logic [md_pkg::DATA_W-1:0]   div_result_i
);

  md_state_pkg::ctrl_state_e state_q, state_d;

  logic                      accept;
  logic                      is_mult;
  logic                      unit_done;
  logic [md_pkg::DATA_W-1:0] result_q;
  md_pkg::md_req_t           op_q;

  // new requests are only taken while ack_o is low
  assign accept  = (state_q == md_state_pkg::CTRL_IDLE) && req_i;
  assign is_mult = (req_data_i.op == md_pkg::MD_OP_MULL) ||
                   (req_data_i.op == md_pkg::MD_OP_MULH);

  // only the started unit ever pulses done
  assign unit_done = mult_done_i | div_done_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      md_state_pkg::CTRL_IDLE: begin
        if (req_i) begin
          state_d = md_state_pkg::CTRL_BUSY;
        end
      end
      md_state_pkg::CTRL_BUSY: begin
        if (unit_done) begin
          state_d = md_state_pkg::CTRL_ACK;
        end
      end
      md_state_pkg::CTRL_ACK: begin
        // result held here for as long as req_i stays high
        if (!req_i) begin
          state_d = md_state_pkg::CTRL_IDLE;
        end
      end
      default: begin
        state_d = md_state_pkg::CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= md_state_pkg::CTRL_IDLE;
      mult_start_o <= 1'b0;
      div_start_o  <= 1'b0;
    end else begin
      state_q      <= state_d;
      mult_start_o <= accept && is_mult;
      div_start_o  <= accept && !is_mult;
    end
  end

  // captured request and result
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= req_data_i;
    end
    if ((state_q == md_state_pkg::CTRL_BUSY) && unit_done) begin
      result_q <= mult_done_i ? mult_result_i : div_result_i;
    end
  end

  assign op_o     = op_q;
  assign result_o = result_q;
  assign ack_o    = (state_q == md_state_pkg::CTRL_ACK);

  // back-pressure: ack_o is held until the requester drops req_i
  ack_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o && req_i |=> ack_o);

  start_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mult_start_o && div_start_o));

endmodule

//--- source/md_mult_fast.sv
// ==========================================================
// fast multiplier
// one signed 17x17 multiply-accumulate stepped over the
// 16-bit partial products, 3 cycles MULL and 4 cycles MULH
// ==========================================================

`timescale 1ns/1ps

module md_mult_fast (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  md_pkg::md_req_t           req_i,
  output logic                      done_o,
  output logic [md_pkg::DATA_W-1:0] result_o
);

  md_state_pkg::mult_state_e state_q, state_d;

  logic [md_pkg::HALF_W-1:0]        al, ah, bl, bh;
  logic                             sign_a, sign_b;
  logic                             signed_mult;
  logic                             is_mull;
  logic                             step;
  logic signed [md_pkg::HALF_W:0]   mult_a, mult_b;
  logic signed [md_pkg::ACC_W-1:0]  accum;
  logic signed [md_pkg::ACC_W-1:0]  mac_res;
  logic [md_pkg::ACC_W-1:0]         acc_q, acc_d;
  logic [md_pkg::DATA_W-1:0]        result_q, result_d;
  logic                             done_d;

  assign al = req_i.op_a[md_pkg::HALF_W-1:0];
  assign ah = req_i.op_a[md_pkg::DATA_W-1:md_pkg::HALF_W];
  assign bl = req_i.op_b[md_pkg::HALF_W-1:0];
  assign bh = req_i.op_b[md_pkg::DATA_W-1:md_pkg::HALF_W];

  assign is_mull     = (req_i.op == md_pkg::MD_OP_MULL);
  assign signed_mult = (req_i.signed_mode != 2'b00);

  // the top two bits of the 35-bit sum always match, so 34 bits hold it
  assign mac_res = mult_a * mult_b + accum;

  // ALBL doubles as the idle state
  assign step = start_i || (state_q != md_state_pkg::ALBL);

  always_comb begin
    sign_a   = 1'b0;
    sign_b   = 1'b0;
    mult_a   = {sign_a, al};
    mult_b   = {sign_b, bl};
    accum    = '0;
    acc_d    = mac_res;
    result_d = result_q;
    done_d   = 1'b0;
    state_d  = state_q;

    unique case (state_q)
      md_state_pkg::ALBL: begin
        mult_a = {1'b0, al};
        mult_b = {1'b0, bl};
        accum  = '0;
        if (start_i) begin
          state_d = md_state_pkg::ALBH;
        end
      end

      md_state_pkg::ALBH: begin
        sign_b = req_i.signed_mode[1] & req_i.op_b[md_pkg::DATA_W-1];
        mult_a = {1'b0, al};
        mult_b = {sign_b, bh};
        // al*bl is unsigned, only its upper half carries on
        accum  = {18'b0, acc_q[31:16]};
        if (is_mull) begin
          // keep al*bl low half in the bottom of the accumulator
          acc_d = {2'b0, mac_res[15:0], acc_q[15:0]};
        end
        state_d = md_state_pkg::AHBL;
      end

      md_state_pkg::AHBL: begin
        sign_a = req_i.signed_mode[0] & req_i.op_a[md_pkg::DATA_W-1];
        mult_a = {sign_a, ah};
        mult_b = {1'b0, bl};
        if (is_mull) begin
          accum    = {18'b0, acc_q[31:16]};
          result_d = {mac_res[15:0], acc_q[15:0]};
          done_d   = 1'b1;
          state_d  = md_state_pkg::ALBL;
        end else begin
          accum   = acc_q;
          state_d = md_state_pkg::AHBH;
        end
      end

      md_state_pkg::AHBH: begin
        // MULH only
        sign_a   = req_i.signed_mode[0] & req_i.op_a[md_pkg::DATA_W-1];
        sign_b   = req_i.signed_mode[1] & req_i.op_b[md_pkg::DATA_W-1];
        mult_a   = {sign_a, ah};
        mult_b   = {sign_b, bh};
        accum    = {{16{signed_mult & acc_q[33]}}, acc_q[33:16]};
        result_d = mac_res[md_pkg::DATA_W-1:0];
        done_d   = 1'b1;
        state_d  = md_state_pkg::ALBL;
      end

      default: begin
        state_d = md_state_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_state_pkg::ALBL;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_o  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step) begin
      acc_q <= acc_d;
    end
    result_q <= result_d;
  end

  assign result_o = result_q;

  mult_state_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

endmodule

//--- source/md_div_long.sv
// ==========================================================
// long divider
// radix-2 restoring division on absolute values with a
// final sign fix, one compare/subtract step per cycle
// ==========================================================

`timescale 1ns/1ps

module md_div_long (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  md_pkg::md_req_t           req_i,
  output logic                      done_o,
  output logic [md_pkg::DATA_W-1:0] result_o
);

  md_state_pkg::div_state_e state_q, state_d;

  logic [md_pkg::DATA_W-1:0] numer_q, numer_d;
  logic [md_pkg::DATA_W-1:0] denom_q, denom_d;
  logic [md_pkg::DATA_W-1:0] quot_q, quot_d;
  logic [md_pkg::DATA_W-1:0] rem_q, rem_d;
  logic [md_pkg::CNT_W-1:0]  cnt_q, cnt_d;

  // the divider's own subtract adder
  logic [md_pkg::DATA_W-1:0] add_a, add_b;
  logic [md_pkg::DATA_W:0]   diff;

  logic                      is_div;
  logic                      sign_a, sign_b;
  logic                      b_zero;
  logic                      ge;
  logic                      quot_neg;
  logic                      rem_neg;
  logic [md_pkg::DATA_W-1:0] next_rem;
  logic [md_pkg::DATA_W-1:0] next_quot;

  assign is_div = (req_i.op == md_pkg::MD_OP_DIV);
  assign sign_a = req_i.signed_mode[0] & req_i.op_a[md_pkg::DATA_W-1];
  assign sign_b = req_i.signed_mode[1] & req_i.op_b[md_pkg::DATA_W-1];

  // 33-bit unsigned subtract, bit 32 is the borrow
  assign diff = {1'b0, add_a} - {1'b0, add_b};

  // in idle the adder forms 0 - B, which is zero only for B == 0
  assign b_zero = (diff[md_pkg::DATA_W-1:0] == '0);

  // remainder >= divisor when the subtract does not borrow
  assign ge        = ~diff[md_pkg::DATA_W];
  assign next_rem  = ge ? diff[md_pkg::DATA_W-1:0] : rem_q;
  assign next_quot = {quot_q[md_pkg::DATA_W-2:0], ge};

  // zero divisors never reach the sign step, so quot_neg needs no zero check
  assign quot_neg = sign_a ^ sign_b;
  assign rem_neg  = sign_a;

  always_comb begin
    add_a   = '0;
    add_b   = req_i.op_b;
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    cnt_d   = cnt_q;
    done_o  = 1'b0;
    state_d = state_q;

    unique case (state_q)
      md_state_pkg::DIV_IDLE: begin
        if (start_i) begin
          // architectural divide-by-zero results, kept if we skip ahead
          rem_d   = is_div ? '1 : req_i.op_a;
          state_d = b_zero ? md_state_pkg::DIV_FINISH : md_state_pkg::DIV_ABS_A;
        end
      end

      md_state_pkg::DIV_ABS_A: begin
        add_b   = req_i.op_a;
        numer_d = sign_a ? diff[md_pkg::DATA_W-1:0] : req_i.op_a;
        state_d = md_state_pkg::DIV_ABS_B;
      end

      md_state_pkg::DIV_ABS_B: begin
        add_b   = req_i.op_b;
        denom_d = sign_b ? diff[md_pkg::DATA_W-1:0] : req_i.op_b;
        // first partial remainder is the dividend MSB
        rem_d   = {{(md_pkg::DATA_W-1){1'b0}}, numer_q[md_pkg::DATA_W-1]};
        cnt_d   = md_pkg::CNT_W'(md_pkg::DATA_W - 1);
        state_d = md_state_pkg::DIV_COMP;
      end

      md_state_pkg::DIV_COMP: begin
        add_a   = rem_q;
        add_b   = denom_q;
        quot_d  = next_quot;
        // next_rem is below the divisor, so its MSB is always clear
        rem_d   = {next_rem[md_pkg::DATA_W-2:0], numer_q[cnt_q - 1'b1]};
        cnt_d   = cnt_q - 1'b1;
        if (cnt_q == md_pkg::CNT_W'(1)) begin
          state_d = md_state_pkg::DIV_LAST;
        end
      end

      md_state_pkg::DIV_LAST: begin
        add_a   = rem_q;
        add_b   = denom_q;
        // from here rem_q carries whichever value the op returns
        rem_d   = is_div ? next_quot : next_rem;
        state_d = md_state_pkg::DIV_SIGN;
      end

      md_state_pkg::DIV_SIGN: begin
        add_b = rem_q;
        if (is_div ? quot_neg : rem_neg) begin
          rem_d = diff[md_pkg::DATA_W-1:0];
        end
        state_d = md_state_pkg::DIV_FINISH;
      end

      md_state_pkg::DIV_FINISH: begin
        done_o  = 1'b1;
        state_d = md_state_pkg::DIV_IDLE;
      end

      default: begin
        state_d = md_state_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_state_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // operand and partial result registers
  always_ff @(posedge clk_i) begin
    numer_q <= numer_d;
    denom_q <= denom_d;
    quot_q  <= quot_d;
    rem_q   <= rem_d;
  end

  assign result_o = rem_q;

  div_state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {md_state_pkg::DIV_IDLE, md_state_pkg::DIV_ABS_A,
                    md_state_pkg::DIV_ABS_B, md_state_pkg::DIV_COMP,
                    md_state_pkg::DIV_LAST, md_state_pkg::DIV_SIGN,
                    md_state_pkg::DIV_FINISH});

endmodule

//--- source/md_top.sv
// ==========================================================
// multiply/divide unit top level
// request controller with fast multiplier and long divider
// ==========================================================

`timescale 1ns/1ps

module md_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  md_pkg::md_req_t           req_data_i,
  output logic                      ack_o,
  output logic [md_pkg::DATA_W-1:0] result_o
);

  md_pkg::md_req_t           op;
  logic                      mult_start;
  logic                      div_start;
  logic                      mult_done;
  logic                      div_done;
  logic [md_pkg::DATA_W-1:0] mult_result;
  logic [md_pkg::DATA_W-1:0] div_result;

  md_req_ctrl md_req_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .ack_o         (ack_o),
    .result_o      (result_o),
    .op_o          (op),
    .mult_start_o  (mult_start),
    .div_start_o   (div_start),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .div_done_i    (div_done),
    .div_result_i  (div_result)
  );

  md_mult_fast md_mult_fast_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mult_start),
    .req_i    (op),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  md_div_long md_div_long_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .req_i    (op),
    .done_o   (div_done),
    .result_o (div_result)
  );

endmodule

//--- dv/md_tb.sv
// ==========================================================
// multiply/divide unit testbench
// LCG stimulus over the req/ack handshake, reference model
// and concurrent assertions on ack_o and result_o
// ==========================================================

`timescale 1ns/1ps

module md_tb;

  localparam logic [31:0] MIN_VAL  = 32'h8000_0000;
  localparam logic [31:0] ONES_VAL = 32'hFFFF_FFFF;

  // about 60 operations of under 48 cycles each including the hold and some margin
  localparam int MAX_CYCLES = 4000;

  logic                      clk;
  logic                      rst_n;
  logic                      req;
  md_pkg::md_req_t           req_data;
  logic                      ack;
  logic [md_pkg::DATA_W-1:0] result;
  logic [md_pkg::DATA_W-1:0] exp_result;
  logic [31:0]               lcg_state;
  int unsigned               cycle_cnt = 0;

  md_top md_top_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .result_o   (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // upper halves of two steps since the low LCG bits repeat too quickly
  function logic [31:0] next_rand();
    logic [31:0] hi;
    lcg_state = lcg_step(lcg_state);
    hi = lcg_state;
    lcg_state = lcg_step(lcg_state);
    return {hi[31:16], lcg_state[31:16]};
  endfunction

  // architectural result on 64-bit extended operands
  function automatic logic [31:0] ref_result(input md_pkg::md_req_t r);
    logic signed [63:0] a64;
    logic signed [63:0] b64;
    logic signed [63:0] prod;
    logic signed [63:0] quot;
    logic signed [63:0] rem;
    logic [31:0]        res;
    a64  = r.signed_mode[0] ? {{32{r.op_a[31]}}, r.op_a} : {32'b0, r.op_a};
    b64  = r.signed_mode[1] ? {{32{r.op_b[31]}}, r.op_b} : {32'b0, r.op_b};
    prod = a64 * b64;
    res  = '0;
    case (r.op)
      md_pkg::MD_OP_MULL: res = prod[31:0];
      md_pkg::MD_OP_MULH: res = prod[63:32];
      md_pkg::MD_OP_DIV: begin
        if (r.op_b == '0) begin
          res = '1;
        end else begin
          // truncates toward zero and MIN / -1 wraps back to MIN
          quot = a64 / b64;
          res  = quot[31:0];
        end
      end
      default: begin
        if (r.op_b == '0) begin
          res = r.op_a;
        end else begin
          rem = a64 % b64;
          res = rem[31:0];
        end
      end
    endcase
    return res;
  endfunction

  // one full four-phase transaction entered and left 2 ns after an edge
  task automatic run_op(input md_pkg::md_op_e op, input logic [1:0] mode,
                        input logic [31:0] a, input logic [31:0] b);
    md_pkg::md_req_t r;
    logic [31:0]     rnd;
    r.op          = op;
    r.signed_mode = mode;
    r.op_a        = a;
    r.op_b        = b;
    rnd           = next_rand();
    req_data      = r;
    exp_result    = ref_result(r);
    req           = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!ack);
    // extra cycles with req held and result expected to stay put
    repeat (int'(rnd[1:0])) begin
      @(posedge clk);
      #2;
    end
    req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (ack);
  endtask

  ack_reset_a: assert property (@(posedge clk) !rst_n |-> !ack)
    else begin
      $display("ack_o was high during reset");
      abort_run();
    end

  ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else begin
      $display("ack_o rose while req_i was low");
      abort_run();
    end

  ack_fall_a: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> !$past(req))
    else begin
      $display("ack_o fell before req_i had been seen low");
      abort_run();
    end

  result_a: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> result == exp_result)
    else begin
      $display("ERROR: result_o expected %h got %h", $sampled(exp_result), $sampled(result));
      abort_run();
    end

  result_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(result))
    else begin
      $display("ERROR: result_o expected %h got %h", $past(result), $sampled(result));
      abort_run();
    end

  initial begin
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     rnd;
    md_pkg::md_op_e  op;
    logic [1:0]      mode;
    rst_n      = 1'b0;
    req        = 1'b0;
    req_data   = '0;
    exp_result = '0;
    lcg_state  = 32'd17;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    for (int i = 0; i < 8; i++) begin
      rnd = next_rand();
      a   = next_rand();
      b   = next_rand();
      run_op(md_pkg::MD_OP_MULL, rnd[1:0], a, b);
    end

    // MULH, MULHSU-style mixes and MULHU
    for (int m = 0; m < 4; m++) begin
      for (int i = 0; i < 3; i++) begin
        a = next_rand();
        b = next_rand();
        run_op(md_pkg::MD_OP_MULH, 2'(m), a, b);
      end
      run_op(md_pkg::MD_OP_MULH, 2'(m), MIN_VAL, ONES_VAL);
      run_op(md_pkg::MD_OP_MULH, 2'(m), ONES_VAL, MIN_VAL);
      run_op(md_pkg::MD_OP_MULH, 2'(m), MIN_VAL, MIN_VAL);
      run_op(md_pkg::MD_OP_MULH, 2'(m), ONES_VAL, ONES_VAL);
    end

    // shifted divisors give quotients of every size
    for (int i = 0; i < 12; i++) begin
      a    = next_rand();
      rnd  = next_rand();
      b    = next_rand() >> rnd[4:0];
      mode = i[0] ? 2'b11 : 2'b00;
      op   = i[1] ? md_pkg::MD_OP_REM : md_pkg::MD_OP_DIV;
      run_op(op, mode, a, b);
    end

    // divide by zero and the signed overflow case
    a = next_rand();
    run_op(md_pkg::MD_OP_DIV, 2'b11, a, '0);
    run_op(md_pkg::MD_OP_REM, 2'b11, a, '0);
    run_op(md_pkg::MD_OP_DIV, 2'b00, a, '0);
    run_op(md_pkg::MD_OP_REM, 2'b00, a, '0);
    run_op(md_pkg::MD_OP_DIV, 2'b11, MIN_VAL, ONES_VAL);
    run_op(md_pkg::MD_OP_REM, 2'b11, MIN_VAL, ONES_VAL);
    run_op(md_pkg::MD_OP_DIV, 2'b00, MIN_VAL, ONES_VAL);
    run_op(md_pkg::MD_OP_REM, 2'b00, MIN_VAL, ONES_VAL);

    repeat (2) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- filelist.f
source/md_pkg.sv
source/md_state_pkg.sv
source/md_req_ctrl.sv
source/md_mult_fast.sv
source/md_div_long.sv
source/md_top.sv
dv/md_tb.sv
